// File: verilog/rv_core_pkg.sv
`default_nettype none

package rv_core_pkg;

    // Data, address and instruction words share one width
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        opcode_load   = 7'b0000011,
        opcode_op_imm = 7'b0010011,
        opcode_auipc  = 7'b0010111,
        opcode_store  = 7'b0100011,
        opcode_op     = 7'b0110011,
        opcode_lui    = 7'b0110111,
        opcode_branch = 7'b1100011,
        opcode_jal    = 7'b1101111
    } opcode_t;

    // ALU operation codes, gaps left for later ops
    typedef enum logic [3:0] {
        alu_add  = 4'b0000,
        alu_sub  = 4'b0001,
        alu_and  = 4'b0010,
        alu_or   = 4'b0011,
        alu_slt  = 4'b0101,
        alu_sltu = 4'b0111,
        alu_xor  = 4'b1000
    } alu_op_t;

    typedef enum logic [2:0] {
        imm_i = 3'b000,
        imm_s = 3'b001,
        imm_b = 3'b010,
        imm_j = 3'b011,
        imm_u = 3'b100
    } imm_src_t;

    // Register write-back selection
    typedef enum logic [1:0] {
        wb_alu      = 2'b00,
        wb_mem      = 2'b01,
        wb_pc_plus4 = 2'b10, // Link address for jal
        wb_upper    = 2'b11  // lui / auipc
    } wb_src_t;

endpackage

`default_nettype wire

// File: verilog/ctrl_if.sv
`timescale 1ns/100ps
`default_nettype none

interface ctrl_if import rv_core_pkg::*; ();

    alu_op_t  alu_control;
    imm_src_t imm_source;
    logic     mem_write;
    logic     reg_write;
    logic     alu_source;        // 1 selects the immediate as operand B
    wb_src_t  write_back_source;
    logic     pc_source;         // 1 takes the branch / jump target
    logic     second_add_source; // 1 zeroes the adder base for lui

    modport decoder (
        output alu_control, imm_source, mem_write, reg_write,
        output alu_source, write_back_source, pc_source, second_add_source
    );

    modport datapath (
        input alu_control, imm_source, mem_write, reg_write,
        input alu_source, write_back_source, pc_source, second_add_source
    );

endinterface

`default_nettype wire

// File: verilog/control.sv
`timescale 1ns/100ps
`default_nettype none

module control import rv_core_pkg::*; (
    input  opcode_t      op,
    input  logic [2:0]   func3,
    input  logic [6:0]   func7,
    input  logic         alu_zero,
    ctrl_if.decoder      ctrl
);

    // Class of ALU work requested by the main decoder
    localparam logic [1:0] alu_op_add   = 2'b00;
    localparam logic [1:0] alu_op_sub   = 2'b01;
    localparam logic [1:0] alu_op_funct = 2'b10;

    logic [1:0] alu_op;
    logic       branch;
    logic       jump;

    // Main decoder
    always_comb begin
        // Safe defaults leave registers and memory untouched
        ctrl.reg_write         = 1'b0;
        ctrl.mem_write         = 1'b0;
        ctrl.imm_source        = imm_i;
        ctrl.alu_source        = 1'b0;
        ctrl.write_back_source = wb_alu;
        ctrl.second_add_source = 1'b0;
        alu_op                 = alu_op_add;
        branch                 = 1'b0;
        jump                   = 1'b0;

        case (op)
            opcode_load: begin
                ctrl.reg_write         = 1'b1;
                ctrl.alu_source        = 1'b1; // Base plus offset
                ctrl.write_back_source = wb_mem;
            end
            opcode_op_imm: begin
                ctrl.reg_write  = 1'b1;
                ctrl.alu_source = 1'b1;
                alu_op          = alu_op_funct;
            end
            opcode_store: begin
                ctrl.mem_write  = 1'b1;
                ctrl.imm_source = imm_s;
                ctrl.alu_source = 1'b1;
            end
            opcode_op: begin
                ctrl.reg_write = 1'b1;
                alu_op         = alu_op_funct;
            end
            opcode_branch: begin
                ctrl.imm_source = imm_b;
                alu_op          = alu_op_sub; // Equality through the zero flag
                branch          = 1'b1;
            end
            opcode_jal: begin
                ctrl.reg_write         = 1'b1;
                ctrl.imm_source        = imm_j;
                ctrl.write_back_source = wb_pc_plus4;
                jump                   = 1'b1;
            end
            opcode_lui, opcode_auipc: begin
                ctrl.reg_write         = 1'b1;
                ctrl.imm_source        = imm_u;
                ctrl.write_back_source = wb_upper;
                // Opcode bit 5 tells lui from auipc
                ctrl.second_add_source = (op == opcode_lui);
            end
            default: begin
                // Unsupported opcode, defaults hold
            end
        endcase
    end

    // ALU decoder
    always_comb begin
        ctrl.alu_control = alu_add;
        case (alu_op)
            alu_op_sub: ctrl.alu_control = alu_sub;
            alu_op_funct: begin
                case (func3)
                    3'b000: begin
                        // Only R-type uses funct7 to pick sub
                        if (op == opcode_op && func7[5]) begin
                            ctrl.alu_control = alu_sub;
                        end else begin
                            ctrl.alu_control = alu_add;
                        end
                    end
                    3'b111:  ctrl.alu_control = alu_and;
                    3'b110:  ctrl.alu_control = alu_or;
                    3'b010:  ctrl.alu_control = alu_slt;
                    3'b011:  ctrl.alu_control = alu_sltu;
                    3'b100:  ctrl.alu_control = alu_xor;
                    default: ctrl.alu_control = alu_add;
                endcase
            end
            default: ctrl.alu_control = alu_add; // Address and upper forms
        endcase
    end

    assign ctrl.pc_source = (alu_zero & branch) | jump;

    // No opcode both writes memory and a register
    always_comb begin
        assert final (!(ctrl.mem_write && ctrl.reg_write))
            else $error("control: mem_write and reg_write both set");
    end

endmodule

`default_nettype wire

// File: verilog/imm_extend.sv
`timescale 1ns/100ps
`default_nettype none

module imm_extend import rv_core_pkg::*; (
    input  word_t    instr,
    input  imm_src_t imm_source,
    output word_t    imm
);

    always_comb begin
        case (imm_source)
            imm_i: begin
                imm = {{20{instr[31]}}, instr[31:20]};
            end
            imm_s: begin
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            imm_b: begin
                // Halfword offset, bit 0 always clear
                imm = {{20{instr[31]}}, instr[7], instr[30:25],
                       instr[11:8], 1'b0};
            end
            imm_j: begin
                imm = {{12{instr[31]}}, instr[19:12], instr[20],
                       instr[30:21], 1'b0};
            end
            imm_u: begin
                imm = {instr[31:12], 12'b0}; // Upper 20 bits, low part zero
            end
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/alu.sv
`timescale 1ns/100ps
`default_nettype none

module alu import rv_core_pkg::*; (
    input  word_t   a,
    input  word_t   b,
    input  alu_op_t alu_control,
    output word_t   result,
    output logic    zero
);

    logic signed_less;
    logic unsigned_less;

    assign signed_less   = $signed(a) < $signed(b);
    assign unsigned_less = a < b;

    always_comb begin
        case (alu_control)
            alu_add:  result = a + b;
            alu_sub:  result = a - b;
            alu_and:  result = a & b;
            alu_or:   result = a | b;
            alu_xor:  result = a ^ b;
            alu_slt:  result = {31'b0, signed_less};
            alu_sltu: result = {31'b0, unsigned_less};
            default:  result = '0;
        endcase
    end

    // Feeds the beq decision
    assign zero = (result == '0);

    // A zero difference means equal operands, as beq expects
    always_comb begin
        assert final (alu_control != alu_sub || zero == (a == b))
            else $error("alu: zero flag disagrees with operand equality");
    end

endmodule

`default_nettype wire

// File: verilog/reg_file.sv
`timescale 1ns/100ps
`default_nettype none

module reg_file import rv_core_pkg::*; (
    input  logic      clk,
    input  reg_addr_t read_addr1,
    input  reg_addr_t read_addr2,
    output word_t     read_data1,
    output word_t     read_data2,
    input  logic      write_enable,
    input  reg_addr_t write_addr,
    input  word_t     write_data
);

    word_t regs [32];

    // x0 is never written
    always_ff @(posedge clk) begin
        if (write_enable && write_addr != '0) begin
            regs[write_addr] <= write_data;
        end
    end

    // Hardwired zero on x0 reads
    assign read_data1 = (read_addr1 == '0) ? '0 : regs[read_addr1];
    assign read_data2 = (read_addr2 == '0) ? '0 : regs[read_addr2];

endmodule

`default_nettype wire

// File: verilog/rv_core.sv
`timescale 1ns/100ps
`default_nettype none

module rv_core import rv_core_pkg::*; #(
    parameter word_t reset_pc = 32'h0000_0000
) (
    input  logic  clk,
    input  logic  reset,

    // Instruction memory
    output word_t instr_addr,
    input  word_t instr,

    // Data memory
    output word_t data_addr,
    output word_t data_write_data,
    output logic  data_write_enable,
    input  word_t data_read_data
);

    word_t     pc;
    word_t     pc_next;
    word_t     pc_plus4;
    word_t     second_add_result; // Branch / jump target and upper result
    word_t     imm;
    word_t     read_data1;
    word_t     read_data2;
    word_t     alu_b;
    word_t     alu_result;
    logic      alu_zero;
    word_t     write_back_data;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    reg_addr_t rd_addr;

    ctrl_if ctrl ();

    assign rs1_addr = instr[19:15];
    assign rs2_addr = instr[24:20];
    assign rd_addr  = instr[11:7];

    control control_i (
        .op       (opcode_t'(instr[6:0])),
        .func3    (instr[14:12]),
        .func7    (instr[31:25]),
        .alu_zero (alu_zero),
        .ctrl     (ctrl.decoder)
    );

    imm_extend imm_extend_i (
        .instr      (instr),
        .imm_source (ctrl.imm_source),
        .imm        (imm)
    );

    reg_file reg_file_i (
        .clk          (clk),
        .read_addr1   (rs1_addr),
        .read_addr2   (rs2_addr),
        .read_data1   (read_data1),
        .read_data2   (read_data2),
        .write_enable (ctrl.reg_write & ~reset), // No write during reset
        .write_addr   (rd_addr),
        .write_data   (write_back_data)
    );

    assign alu_b = ctrl.alu_source ? imm : read_data2;

    alu alu_i (
        .a           (read_data1),
        .b           (alu_b),
        .alu_control (ctrl.alu_control),
        .result      (alu_result),
        .zero        (alu_zero)
    );

    assign pc_plus4 = pc + 32'd4;

    // Base is the PC except for lui
    assign second_add_result = (ctrl.second_add_source ? '0 : pc) + imm;

    assign pc_next = ctrl.pc_source ? second_add_result : pc_plus4;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= reset_pc;
        end else begin
            pc <= pc_next;
        end
    end

    always_comb begin
        case (ctrl.write_back_source)
            wb_alu:      write_back_data = alu_result;
            wb_mem:      write_back_data = data_read_data;
            wb_pc_plus4: write_back_data = pc_plus4;
            default:     write_back_data = second_add_result; // Upper forms
        endcase
    end

    assign instr_addr        = pc;
    assign data_addr         = alu_result;
    assign data_write_data   = read_data2;
    assign data_write_enable = ctrl.mem_write & ~reset;

    // A branch or jump offset with bit 1 set would break word alignment
    pc_aligned_a: assert property (@(posedge clk) disable iff (reset)
        pc[1:0] == 2'b00)
        else $error("rv_core: PC not word aligned");

endmodule

`default_nettype wire

// File: tests/rv_core_tb.sv
`timescale 1ns/100ps
`default_nettype none

module rv_core_tb import rv_core_pkg::*; ();

    localparam int mem_words = 256;

    logic  clk;
    logic  reset;
    word_t instr_addr;
    word_t instr;
    word_t data_addr;
    word_t data_write_data;
    logic  data_write_enable;
    word_t data_read_data;

    word_t imem [mem_words];
    word_t dmem [mem_words];

    word_t m_pc; // Reference model state
    word_t m_regs [32];
    word_t m_dmem [mem_words];
    word_t m_instr;
    logic  exp_store;
    word_t exp_addr;
    word_t exp_data;

    word_t lcg_state;
    word_t section_end [5];
    int    prog_len;
    int    store_offset;
    int    timeout_limit;
    int    cycle_count;
    int    error_count;
    int    errors_at_start;
    int    tests_passed;
    int    tests_failed;

    rv_core #(.reset_pc(32'h0)) dut_i (
        .clk               (clk),
        .reset             (reset),
        .instr_addr        (instr_addr),
        .instr             (instr),
        .data_addr         (data_addr),
        .data_write_data   (data_write_data),
        .data_write_enable (data_write_enable),
        .data_read_data    (data_read_data)
    );

    always #4 clk = ~clk;

    // Combinational memory reads, data written on the strobe
    assign instr          = imem[instr_addr[9:2]];
    assign data_read_data = dmem[data_addr[9:2]];

    always @(posedge clk) begin
        if (data_write_enable) begin
            dmem[data_addr[9:2]] <= data_write_data;
        end
    end

    function automatic word_t next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic word_t r_type(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                     logic [2:0] f3, logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic word_t i_type(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                     logic [4:0] rd, logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic word_t s_type(logic [11:0] imm, logic [4:0] rs2);
        return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], 7'b0100011}; // sw rs2, imm(x0)
    endfunction

    function automatic word_t b_type(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1);
        return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic word_t j_type(logic [20:0] imm, logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    // ISA result for op and op_imm
    function automatic word_t isa_alu_result(logic [2:0] f3, logic sub, word_t a, word_t b);
        case (f3)
            3'b000:  return sub ? a - b : a + b;
            3'b111:  return a & b;
            3'b110:  return a | b;
            3'b100:  return a ^ b;
            3'b010:  return {31'b0, $signed(a) < $signed(b)};
            3'b011:  return {31'b0, a < b};
            default: return 32'h0;
        endcase
    endfunction

    task automatic emit(word_t word);
        imem[prog_len[7:0]] = word;
        prog_len++;
    endtask

    task automatic store_result(logic [4:0] rs);
        emit(s_type(12'(store_offset), rs));
        store_offset += 4;
    endtask

    task automatic build_program();
        logic [2:0] f3_list [7];
        word_t      rnd;
        f3_list = '{3'b000, 3'b000, 3'b111, 3'b110, 3'b100, 3'b010, 3'b011};
        store_result(5'd0); // Sits at the reset PC while reset is high
        for (int k = 0; k < 3; k++) begin
            emit(i_type(12'(4 * k), 5'd0, 3'b010, 5'(k + 1), 7'b0000011)); // lw x1..x3
        end
        for (int k = 0; k < 7; k++) begin // add sub and or xor slt sltu
            emit(r_type((k == 1) ? 7'h20 : 7'h00, (k % 2 == 0) ? 5'd2 : 5'd3, 5'd1,
                        f3_list[k], 5'(k + 4)));
            store_result(5'(k + 4));
        end
        for (int k = 1; k < 7; k++) begin // Immediate forms, sub slot skipped
            rnd = next_random();
            emit(i_type(rnd[31:20], 5'd1, f3_list[k], 5'(k + 11), 7'b0010011));
            store_result(5'(k + 11));
        end
        section_end[1] = 32'(prog_len * 4);
        emit(i_type(12'd17, 5'd0, 3'b000, 5'd20, 7'b0010011));
        emit(i_type(12'd19, 5'd0, 3'b000, 5'd23, 7'b0010011));
        emit(b_type(13'd8, 5'd1, 5'd1)); // Taken
        emit(i_type(12'd1, 5'd0, 3'b000, 5'd20, 7'b0010011));
        emit(b_type(13'd8, 5'd2, 5'd1)); // Not taken unless x1 equals x2
        emit(i_type(12'd5, 5'd0, 3'b000, 5'd21, 7'b0010011));
        emit(j_type(21'd8, 5'd22));
        emit(i_type(12'd7, 5'd0, 3'b000, 5'd23, 7'b0010011));
        for (int k = 20; k < 24; k++) begin
            store_result(5'(k));
        end
        section_end[2] = 32'(prog_len * 4);
        rnd = next_random();
        emit({rnd[31:12], 5'd24, 7'b0110111}); // lui
        rnd = next_random();
        emit({rnd[31:12], 5'd25, 7'b0010111}); // auipc
        store_result(5'd24);
        store_result(5'd25);
        section_end[3] = 32'(prog_len * 4);
        emit(i_type(12'd123, 5'd1, 3'b000, 5'd0, 7'b0010011));
        emit(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd0));
        store_result(5'd0);
        emit({7'h00, 5'd3, 5'd1, 3'b000, 5'd4, 7'b0001011}); // Custom opcode, add-shaped
        emit({7'h00, 5'd4, 5'd0, 3'b010, 5'd0, 7'b0100111}); // Store-like, unsupported
        store_result(5'd4);
        section_end[4] = 32'(prog_len * 4);
        emit(j_type(21'd0, 5'd0)); // Halt loop
    endtask

    task automatic flag_mismatch(string msg);
        $display("Error at %0t: %s", $time, msg);
        error_count++;
    endtask

    task automatic run_to(word_t addr);
        @(posedge clk);
        while (m_pc != addr) begin
            @(posedge clk);
        end
    endtask

    task automatic report_test(int number, string name);
        if (error_count == errors_at_start) begin
            tests_passed++;
        end else begin
            tests_failed++;
        end
        $display("Test %0d %s finished with %0d mismatches", number, name,
                 error_count - errors_at_start);
        errors_at_start = error_count;
    endtask

    // Reference model, one instruction per clock
    always @(posedge clk) begin : reference_step
        word_t ins;
        word_t rs1_val;
        word_t imm_i;
        word_t next_pc;
        if (reset) begin
            m_pc <= 32'h0;
        end else begin
            ins     = imem[m_pc[9:2]];
            rs1_val = m_regs[ins[19:15]];
            imm_i   = {{20{ins[31]}}, ins[31:20]};
            next_pc = m_pc + 32'd4;
            case (ins[6:0])
                7'b0000011: m_regs[ins[11:7]] <= m_dmem[8'((rs1_val + imm_i) >> 2)];
                7'b0010011: m_regs[ins[11:7]] <= isa_alu_result(ins[14:12], 1'b0, rs1_val, imm_i);
                7'b0110011: m_regs[ins[11:7]] <= isa_alu_result(ins[14:12], ins[30], rs1_val,
                                                                m_regs[ins[24:20]]);
                7'b0100011: m_dmem[exp_addr[9:2]] <= exp_data;
                7'b1100011: begin
                    if (rs1_val == m_regs[ins[24:20]]) begin
                        next_pc = m_pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
                    end
                end
                7'b1101111: begin
                    m_regs[ins[11:7]] <= m_pc + 32'd4;
                    next_pc = m_pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
                end
                7'b0110111: m_regs[ins[11:7]] <= {ins[31:12], 12'b0};
                7'b0010111: m_regs[ins[11:7]] <= m_pc + {ins[31:12], 12'b0};
                default: ; // Unknown opcode leaves state alone
            endcase
            m_regs[0] <= 32'h0;
            m_pc      <= next_pc;
        end
    end

    assign m_instr   = imem[m_pc[9:2]];
    assign exp_store = !reset && (m_instr[6:0] == 7'b0100011); // Strobe held low in reset
    assign exp_addr  = m_regs[m_instr[19:15]] + {{20{m_instr[31]}}, m_instr[31:25], m_instr[11:7]};
    assign exp_data  = m_regs[m_instr[24:20]];

    reset_write_a: assert property (@(posedge clk) reset |-> !data_write_enable)
        else flag_mismatch("data_write_enable high during reset");
    first_fetch_a: assert property (@(posedge clk) $fell(reset) |-> instr_addr == 32'h0)
        else flag_mismatch($sformatf("first instr_addr %h", $sampled(instr_addr)));
    pc_match_a: assert property (@(posedge clk) disable iff (reset) instr_addr == m_pc)
        else flag_mismatch($sformatf("instr_addr %h, expected %h",
                                     $sampled(instr_addr), $sampled(m_pc)));
    store_enable_a: assert property (@(posedge clk) disable iff (reset)
        data_write_enable == exp_store)
        else flag_mismatch($sformatf("data_write_enable %b at pc %h",
                                     $sampled(data_write_enable), $sampled(m_pc)));
    store_value_a: assert property (@(posedge clk) disable iff (reset)
        data_write_enable |-> (data_addr == exp_addr && data_write_data == exp_data))
        else flag_mismatch($sformatf("store %h to %h, expected %h to %h",
                                     $sampled(data_write_data), $sampled(data_addr),
                                     $sampled(exp_data), $sampled(exp_addr)));

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (timeout_limit > 0 && cycle_count >= timeout_limit) begin
            $display("Timeout: the program did not reach its end in %0d cycles", timeout_limit);
            $display("Testbench failed");
            $finish;
        end
    end

    initial begin
        clk             = 1'b0;
        reset           = 1'b1;
        lcg_state       = 32'h104a_71af;
        cycle_count     = 0;
        error_count     = 0;
        errors_at_start = 0;
        tests_passed    = 0;
        tests_failed    = 0;
        prog_len        = 0;
        store_offset    = 256;
        for (int i = 0; i < mem_words; i++) begin
            imem[i]   = {i[24:0], 7'b1111111};
            dmem[i]   = {~i[15:0], i[15:0]};
            m_regs[i % 32] = 32'h0;
        end
        for (int i = 0; i < 3; i++) begin
            dmem[i] = next_random();
        end
        m_dmem = dmem;
        build_program();
        timeout_limit = prog_len * 2 + 20;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        repeat (2) @(posedge clk);
        report_test(1, "reset");
        run_to(section_end[1]);
        report_test(2, "register and immediate ALU");
        run_to(section_end[2]);
        report_test(3, "branch and jump");
        run_to(section_end[3]);
        report_test(4, "upper immediates");
        run_to(section_end[4]);
        report_test(5, "register zero and unknown opcodes");
        $display("Tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && error_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: rv_core.f
verilog/rv_core_pkg.sv
verilog/ctrl_if.sv
verilog/control.sv
verilog/imm_extend.sv
verilog/alu.sv
verilog/reg_file.sv
verilog/rv_core.sv
tests/rv_core_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -j 0 --top-module rv_core_tb \
    -f rv_core.f -o rv_core_sim \
    && ./obj_dir/rv_core_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or run failed"; exit 1; }
cat sim.log
grep -qx "Testbench passed" sim.log || exit 1
